/* Makefile */
# Verilator build and run for the tiled dual-port memory

VERILATOR ?= verilator
TOP       ?= tb_dpram
FLIST     ?= dpram.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= -j 0

SRCS    := $(shell grep -v '^+' $(FLIST))
HDRS    := dpram_config.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dpram.f */
+incdir+.
dpram_pkg.sv
dpram_bank.sv
dpram_req_decode.sv
dpram_read_merge.sv
dpram_top.sv
dpram_checker.sv
tb_dpram.sv

/* dpram_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dpram_config.svh"

// behavioral stand-in for one hardened 128x32 dual-port macro
// port A writes with a bit mask, port B reads into an output register
module dpram_bank (
    input  wire                     clk,
    input  wire                     we,       // port A write enable
    input  dpram_pkg::bank_addr_t   wr_addr,
    input  dpram_pkg::word_t        wr_data,
    input  dpram_pkg::word_t        wr_mask,  // 1 = bit is written
    input  wire                     re,       // port B read enable
    input  dpram_pkg::bank_addr_t   rd_addr,
    output dpram_pkg::word_t        dout
);

    localparam int DEPTH = 2 ** `DPRAM_BANK_AW;

    dpram_pkg::word_t mem [0:DEPTH-1];

    // masked write, untouched bits keep their old value
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= (mem[wr_addr] & ~wr_mask) | (wr_data & wr_mask);
        end
    end

    // both ports sample the array before the edge, so a colliding read
    // sees the old word
    always_ff @(posedge clk) begin
        if (re) begin
            dout <= mem[rd_addr];  // held while re is low
        end
    end

endmodule

`default_nettype wire

/* dpram_checker.sv */
`timescale 1ns/1ns
`default_nettype none

// handshake, reset and latency rules on the dpram_top ports
module dpram_checker (
    input wire              clk,
    input wire              rst_n,
    input wire              wr_ready,
    input wire              rd_req_valid,
    input wire              rd_req_ready,
    input wire              rd_rsp_valid,
    input dpram_pkg::word_t rd_rsp_data,
    input wire              rd_rsp_ready
);

    // a stalled response keeps valid and data
    rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_rsp_valid && !rd_rsp_ready) |=> (rd_rsp_valid && $stable(rd_rsp_data)))
        else $error("read response changed while it was stalled");

    reset_idle: assert property (@(posedge clk)
        !rst_n |-> (!wr_ready && !rd_req_ready && !rd_rsp_valid))
        else $error("ready or valid output high during reset");

    // accept at edge N, push at N+1, valid seen at N+2
    rd_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(rd_req_valid && rd_req_ready && rd_rsp_ready, 2) && $past(rd_rsp_ready))
        |-> rd_rsp_valid)
        else $error("read response not valid one cycle after the accepted read");

endmodule

bind dpram_top dpram_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_ready     (wr_ready),
    .rd_req_valid (rd_req_valid),
    .rd_req_ready (rd_req_ready),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .rd_rsp_ready (rd_rsp_ready)
);

`default_nettype wire

/* dpram_config.svh */
`ifndef DPRAM_CONFIG_SVH
`define DPRAM_CONFIG_SVH

// memory geometry, two 128x32 macros tiled side by side

// data word and write mask width
`define DPRAM_DW        32

// full address, msb picks the bank
`define DPRAM_AW        8

// address inside one macro
`define DPRAM_BANK_AW   7

// response buffer entries, also the read credit limit
`define DPRAM_RSP_DEPTH 2

`endif

/* dpram_pkg.sv */
`default_nettype none

`include "dpram_config.svh"

package dpram_pkg;

    // one data word or one write mask
    typedef logic [`DPRAM_DW-1:0] word_t;

    // full memory address
    typedef logic [`DPRAM_AW-1:0] addr_t;

    // address inside a single bank
    typedef logic [`DPRAM_BANK_AW-1:0] bank_addr_t;

    // occupancy of the read response buffer
    typedef enum logic [1:0] {
        RSP_EMPTY = 2'd0,
        RSP_ONE   = 2'd1,
        RSP_TWO   = 2'd2
    } rsp_state_e;

endpackage

`default_nettype wire

/* dpram_read_merge.sv */
`timescale 1ns/1ns
`default_nettype none

module dpram_read_merge (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 rd_issue,       // read enabled this cycle
    input  wire                 rd_issue_bank,
    input  dpram_pkg::word_t    bank0_dout,
    input  dpram_pkg::word_t    bank1_dout,
    output logic                rd_rsp_valid,
    output dpram_pkg::word_t    rd_rsp_data,
    input  wire                 rd_rsp_ready,
    output logic                rsp_pop         // credit back to decoder
);

    logic                   issue_q;   // bank dout is fresh this cycle
    logic                   bank_q;
    dpram_pkg::word_t       merged;
    dpram_pkg::word_t       head;      // oldest response
    dpram_pkg::word_t       tail;
    dpram_pkg::rsp_state_e  state;
    dpram_pkg::rsp_state_e  state_nxt;
    logic                   push;
    logic                   pop;
    logic                   load_head;
    logic                   load_tail;
    logic                   head_from_tail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        bank_q <= rd_issue_bank;  // only looked at with issue_q
    end

    // gated OR of the macro outputs, same as the tiled wrapper does per bit
    assign merged = ({`DPRAM_DW{issue_q && !bank_q}} & bank0_dout)
                  | ({`DPRAM_DW{issue_q &&  bank_q}} & bank1_dout);

    assign push = issue_q;
    assign pop  = rd_rsp_valid && rd_rsp_ready;

    assign rd_rsp_valid = (state != dpram_pkg::RSP_EMPTY);
    assign rd_rsp_data  = head;
    assign rsp_pop      = pop;

    always_comb begin
        state_nxt      = state;
        load_head      = 1'b0;
        load_tail      = 1'b0;
        head_from_tail = 1'b0;
        unique case (state)
            dpram_pkg::RSP_EMPTY: begin
                if (push) begin
                    load_head = 1'b1;
                    state_nxt = dpram_pkg::RSP_ONE;
                end
            end
            dpram_pkg::RSP_ONE: begin
                if (push && pop) begin
                    load_head = 1'b1;  // straight replace
                end else if (push) begin
                    load_tail = 1'b1;
                    state_nxt = dpram_pkg::RSP_TWO;
                end else if (pop) begin
                    state_nxt = dpram_pkg::RSP_EMPTY;
                end
            end
            dpram_pkg::RSP_TWO: begin
                // credits keep a push from landing here without a pop
                if (pop) begin
                    head_from_tail = 1'b1;
                    if (push) begin
                        load_tail = 1'b1;
                    end else begin
                        state_nxt = dpram_pkg::RSP_ONE;
                    end
                end
            end
            default: begin
                state_nxt = dpram_pkg::RSP_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= dpram_pkg::RSP_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (head_from_tail) begin
            head <= tail;
        end else if (load_head) begin
            head <= merged;
        end
        if (load_tail) begin
            tail <= merged;
        end
    end

endmodule

`default_nettype wire

/* dpram_req_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dpram_config.svh"

module dpram_req_decode (
    input  wire                     clk,
    input  wire                     rst_n,
    // write request
    input  wire                     wr_valid,
    input  dpram_pkg::addr_t        wr_addr,
    input  dpram_pkg::word_t        wr_data,
    input  dpram_pkg::word_t        wr_mask,
    output logic                    wr_ready,
    // read request
    input  wire                     rd_req_valid,
    input  dpram_pkg::addr_t        rd_req_addr,
    output logic                    rd_req_ready,
    input  wire                     rsp_pop,       // credit return from merge
    // bank side
    output logic                    bank0_we,
    output logic                    bank0_re,
    output logic                    bank1_we,
    output logic                    bank1_re,
    output dpram_pkg::bank_addr_t   bank_wr_addr,
    output dpram_pkg::bank_addr_t   bank_rd_addr,
    output dpram_pkg::word_t        bank_wr_data,
    output dpram_pkg::word_t        bank_wr_mask,
    // to merge
    output logic                    rd_issue,
    output logic                    rd_issue_bank
);

    localparam int CREDIT_W = $clog2(`DPRAM_RSP_DEPTH + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`DPRAM_RSP_DEPTH);

    logic                run_q;    // set one edge after reset release
    logic [CREDIT_W-1:0] credit;   // reads in flight or buffered
    logic                wr_fire;
    logic                rd_fire;
    logic                wr_bank;
    logic                rd_bank;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // banks take a write every cycle once out of reset
    assign wr_ready     = run_q;
    assign rd_req_ready = run_q && (credit < CREDIT_MAX);

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_req_valid && rd_req_ready;

    // address msb selects the macro
    assign wr_bank = wr_addr[`DPRAM_AW-1];
    assign rd_bank = rd_req_addr[`DPRAM_AW-1];

    assign bank0_we = wr_fire && !wr_bank;
    assign bank1_we = wr_fire && wr_bank;
    assign bank0_re = rd_fire && !rd_bank;
    assign bank1_re = rd_fire && rd_bank;

    assign bank_wr_addr = wr_addr[`DPRAM_BANK_AW-1:0];
    assign bank_rd_addr = rd_req_addr[`DPRAM_BANK_AW-1:0];
    assign bank_wr_data = wr_data;
    assign bank_wr_mask = wr_mask;

    assign rd_issue      = rd_fire;
    assign rd_issue_bank = rd_bank;

    // one credit per accepted read, returned when its response leaves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= '0;
        end else begin
            case ({rd_fire, rsp_pop})
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;  // none, or one in and one out
            endcase
        end
    end

endmodule

`default_nettype wire

/* dpram_top.sv */
`timescale 1ns/1ns
`default_nettype none

// 256x32 memory tiled from two 128x32 macros, with handshake ports
module dpram_top (
    input  wire                 clk,
    input  wire                 rst_n,
    // write port
    input  wire                 wr_valid,
    input  dpram_pkg::addr_t    wr_addr,
    input  dpram_pkg::word_t    wr_data,
    input  dpram_pkg::word_t    wr_mask,
    output logic                wr_ready,
    // read request
    input  wire                 rd_req_valid,
    input  dpram_pkg::addr_t    rd_req_addr,
    output logic                rd_req_ready,
    // read response
    output logic                rd_rsp_valid,
    output dpram_pkg::word_t    rd_rsp_data,
    input  wire                 rd_rsp_ready
);

    logic                   bank0_we;
    logic                   bank0_re;
    logic                   bank1_we;
    logic                   bank1_re;
    dpram_pkg::bank_addr_t  bank_wr_addr;   // shared by both macros
    dpram_pkg::bank_addr_t  bank_rd_addr;
    dpram_pkg::word_t       bank_wr_data;
    dpram_pkg::word_t       bank_wr_mask;
    dpram_pkg::word_t       bank0_dout;
    dpram_pkg::word_t       bank1_dout;
    logic                   rd_issue;
    logic                   rd_issue_bank;
    logic                   rsp_pop;

    dpram_req_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_mask       (wr_mask),
        .wr_ready      (wr_ready),
        .rd_req_valid  (rd_req_valid),
        .rd_req_addr   (rd_req_addr),
        .rd_req_ready  (rd_req_ready),
        .rsp_pop       (rsp_pop),
        .bank0_we      (bank0_we),
        .bank0_re      (bank0_re),
        .bank1_we      (bank1_we),
        .bank1_re      (bank1_re),
        .bank_wr_addr  (bank_wr_addr),
        .bank_rd_addr  (bank_rd_addr),
        .bank_wr_data  (bank_wr_data),
        .bank_wr_mask  (bank_wr_mask),
        .rd_issue      (rd_issue),
        .rd_issue_bank (rd_issue_bank)
    );

    // lower address half
    dpram_bank u_bank0 (
        .clk     (clk),
        .we      (bank0_we),
        .wr_addr (bank_wr_addr),
        .wr_data (bank_wr_data),
        .wr_mask (bank_wr_mask),
        .re      (bank0_re),
        .rd_addr (bank_rd_addr),
        .dout    (bank0_dout)
    );

    // upper address half
    dpram_bank u_bank1 (
        .clk     (clk),
        .we      (bank1_we),
        .wr_addr (bank_wr_addr),
        .wr_data (bank_wr_data),
        .wr_mask (bank_wr_mask),
        .re      (bank1_re),
        .rd_addr (bank_rd_addr),
        .dout    (bank1_dout)
    );

    dpram_read_merge u_merge (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_issue      (rd_issue),
        .rd_issue_bank (rd_issue_bank),
        .bank0_dout    (bank0_dout),
        .bank1_dout    (bank1_dout),
        .rd_rsp_valid  (rd_rsp_valid),
        .rd_rsp_data   (rd_rsp_data),
        .rd_rsp_ready  (rd_rsp_ready),
        .rsp_pop       (rsp_pop)
    );

endmodule

`default_nettype wire

/* tb_dpram.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dpram_config.svh"

module tb_dpram;

    localparam int WORDS      = 2 ** `DPRAM_AW;
    localparam int CLK_PERIOD = 4;
    localparam int N_PART     = 64;
    localparam int N_RAND     = 600;
    // fill and readback, partial pairs, collisions, back-pressure, random
    localparam int TOTAL_OPS  = 2 * WORDS + 2 * N_PART + 6 + 3 + 2 * N_RAND;

    logic               clk;
    logic               rst_n;
    logic               wr_valid;
    dpram_pkg::addr_t   wr_addr;
    dpram_pkg::word_t   wr_data;
    dpram_pkg::word_t   wr_mask;
    logic               wr_ready;
    logic               rd_req_valid;
    dpram_pkg::addr_t   rd_req_addr;
    logic               rd_req_ready;
    logic               rd_rsp_valid;
    dpram_pkg::word_t   rd_rsp_data;
    logic               rd_rsp_ready;

    dpram_pkg::word_t   ref_mem [0:WORDS-1];
    dpram_pkg::word_t   exp_q [$];   // expected read data, oldest first
    integer             seed;
    int                 wr_cnt;      // accepted writes
    int                 rd_cnt;      // accepted reads
    logic               rand_bp;     // random response back-pressure
    logic               run_ended;

    dpram_top u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        run_ended = 1'b1;
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_response(input dpram_pkg::word_t exp);
        assert (rd_rsp_data === exp) else begin
            $display("Mismatch at time %0t: rd_rsp_data got %h, expected %h",
                     $time, rd_rsp_data, exp);
            abort_run("read data differs from the reference memory");
        end
    endtask

    // call at a falling edge, returns at the falling edge after acceptance
    task automatic issue(input logic do_wr, input dpram_pkg::addr_t wa,
                         input dpram_pkg::word_t wd, input dpram_pkg::word_t wm,
                         input logic do_rd, input dpram_pkg::addr_t ra);
        int wr_goal;
        int rd_goal;
        wr_goal      = wr_cnt + int'(do_wr);
        rd_goal      = rd_cnt + int'(do_rd);
        wr_valid     = do_wr;
        wr_addr      = wa;
        wr_data      = wd;
        wr_mask      = wm;
        rd_req_valid = do_rd;
        rd_req_addr  = ra;
        do begin
            @(negedge clk);
            if (wr_cnt == wr_goal) wr_valid = 1'b0;
            if (rd_cnt == rd_goal) rd_req_valid = 1'b0;
            if (rand_bp) rd_rsp_ready = (($random(seed) & 3) != 0);
        end while (wr_valid || rd_req_valid);
    endtask

    // reference model, read sees the word from before this edge's write
    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_req_valid && rd_req_ready) begin
                exp_q.push_back(ref_mem[rd_req_addr]);
                rd_cnt++;
            end
            if (wr_valid && wr_ready) begin
                for (int b = 0; b < `DPRAM_DW; b++) begin
                    if (wr_mask[b]) begin
                        ref_mem[wr_addr][b] = wr_data[b];  // only masked bits change
                    end
                end
                wr_cnt++;
            end
            if (rd_rsp_valid && rd_rsp_ready) begin
                if (exp_q.size() == 0) begin
                    abort_run("read response arrived with no read outstanding");
                end else begin
                    check_response(exp_q.pop_front());
                end
            end
        end
    end

    initial begin
        dpram_pkg::word_t r;
        int               goal;
        seed         = 32'h0a1c8466;
        clk          = 1'b0;
        rst_n        = 1'b0;
        wr_valid     = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        wr_mask      = '0;
        rd_req_valid = 1'b0;
        rd_req_addr  = '0;
        rd_rsp_ready = 1'b1;
        rand_bp      = 1'b0;
        run_ended    = 1'b0;
        wr_cnt       = 0;
        rd_cnt       = 0;

        repeat (10) @(negedge clk);
        assert (!wr_ready && !rd_req_ready && !rd_rsp_valid)
            else abort_run("ready or valid output high during reset");
        rst_n = 1'b1;
        @(negedge clk);
        assert (wr_ready && rd_req_ready && !rd_rsp_valid)
            else abort_run("ready outputs did not rise after reset release");

        for (int i = 0; i < WORDS; i++) begin   // full-mask fill, both banks
            issue(1'b1, dpram_pkg::addr_t'(i), $random(seed), '1, 1'b0, '0);
        end
        for (int i = 0; i < WORDS; i++) begin
            issue(1'b0, '0, '0, '0, 1'b1, dpram_pkg::addr_t'(i));
        end

        for (int i = 0; i < N_PART; i++) begin  // partial masks
            r = $random(seed);
            issue(1'b1, r[`DPRAM_AW-1:0], $random(seed), $random(seed), 1'b0, '0);
            issue(1'b0, '0, '0, '0, 1'b1, r[`DPRAM_AW-1:0]);
        end

        // same-cycle collision in each bank, then the follow-up read
        issue(1'b1, 8'h1f, 32'hc0de_1f1f, '1, 1'b1, 8'h1f);
        issue(1'b0, '0, '0, '0, 1'b1, 8'h1f);
        issue(1'b1, 8'h9a, 32'h5a5a_0ff0, '1, 1'b1, 8'h9a);
        issue(1'b0, '0, '0, '0, 1'b1, 8'h9a);

        while (exp_q.size() != 0) @(negedge clk);
        rd_rsp_ready = 1'b0;                    // stall responses
        goal         = rd_cnt + 3;
        rd_req_valid = 1'b1;
        rd_req_addr  = 8'h81;
        repeat (12) @(negedge clk);
        assert (rd_cnt == goal - 1 && !rd_req_ready)
            else abort_run("read credits did not hold back the third read");
        rd_rsp_ready = 1'b1;
        while (rd_cnt != goal) @(negedge clk);
        rd_req_valid = 1'b0;

        rand_bp = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin  // mixed traffic
            r = $random(seed);
            issue(r[0], r[8 +: `DPRAM_AW], $random(seed), $random(seed),
                  r[1], r[16 +: `DPRAM_AW]);
        end
        rand_bp      = 1'b0;
        rd_rsp_ready = 1'b1;
        while (exp_q.size() != 0) @(negedge clk);

        run_ended = 1'b1;
        if (rd_req_ready && !rd_rsp_valid) begin  // all credits back, buffer drained
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("read credits or responses left over at the end");
        end
    end

    initial begin
        #(20 * TOTAL_OPS * CLK_PERIOD);
        abort_run("watchdog expired before the run finished");
    end

    final begin
        if (!run_ended) begin  // stopped by a checker assertion
            $display("TEST RESULT: FAIL");
        end
    end

endmodule

`default_nettype wire
